/* exu_pkg.sv */
package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [3:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [2:0]      sys_op_t;

  // rv32 major opcodes
  localparam opcode_t OP_R      = 7'b0110011;
  localparam opcode_t OP_I      = 7'b0010011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  localparam alu_op_t ALU_SGE  = 4'd10;
  localparam alu_op_t ALU_SGEU = 4'd11;

  localparam sys_op_t SYS_NONE   = 3'd0;
  localparam sys_op_t SYS_CSRRW  = 3'd1;
  localparam sys_op_t SYS_CSRRS  = 3'd2;
  localparam sys_op_t SYS_CSRRC  = 3'd3;
  localparam sys_op_t SYS_ECALL  = 3'd4;
  localparam sys_op_t SYS_MRET   = 3'd5;
  localparam sys_op_t SYS_EBREAK = 3'd6;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // environment call from machine mode
  localparam word_t CAUSE_ECALL_M = 32'd11;

  typedef struct packed {
    opcode_t   opcode;
    alu_op_t   alu_op;
    sys_op_t   sys_op;
    reg_idx_t  rd;
    word_t     op1;
    word_t     op2;
    word_t     imm;
    word_t     pc;
    csr_addr_t csr;
  } exu_issue_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     rd_we;
    word_t    wdata;
    logic     redirect;
    word_t    npc;
    logic     ebreak;
  } exu_result_t;

  typedef enum logic {
    MEM_IDLE,
    MEM_WAIT
  } mem_state_e;

  typedef enum logic {
    LSU_IDLE,
    LSU_COUNT
  } lsu_state_e;

endpackage

/* exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::word_t   a_i,
  input  exu_pkg::word_t   b_i,
  input  exu_pkg::alu_op_t op_i,
  output exu_pkg::word_t   res_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      exu_pkg::ALU_ADD: begin
        res_o = a_i + b_i;
      end
      exu_pkg::ALU_SUB: begin
        res_o = a_i - b_i;
      end
      exu_pkg::ALU_AND: begin
        res_o = a_i & b_i;
      end
      exu_pkg::ALU_OR: begin
        res_o = a_i | b_i;
      end
      exu_pkg::ALU_XOR: begin
        res_o = a_i ^ b_i;
      end
      exu_pkg::ALU_SLL: begin
        res_o = a_i << shamt;
      end
      exu_pkg::ALU_SRL: begin
        res_o = a_i >> shamt;
      end
      exu_pkg::ALU_SRA: begin
        res_o = $signed(a_i) >>> shamt;
      end
      // compares give 0 or 1
      exu_pkg::ALU_SLT: begin
        res_o = {31'd0, $signed(a_i) < $signed(b_i)};
      end
      exu_pkg::ALU_SLTU: begin
        res_o = {31'd0, a_i < b_i};
      end
      exu_pkg::ALU_SGE: begin
        res_o = {31'd0, $signed(a_i) >= $signed(b_i)};
      end
      exu_pkg::ALU_SGEU: begin
        res_o = {31'd0, a_i >= b_i};
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

/* exu_branch.sv */
`timescale 1ns/1ps

module exu_branch (
  input  exu_pkg::opcode_t opcode_i,
  input  exu_pkg::alu_op_t alu_op_i,
  input  exu_pkg::sys_op_t sys_op_i,
  input  exu_pkg::word_t   alu_res_i,
  input  exu_pkg::word_t   target_i,
  input  exu_pkg::word_t   mtvec_i,
  input  exu_pkg::word_t   mepc_i,
  output exu_pkg::word_t   npc_o,
  output logic             redirect_o
);

  logic res_zero;

  assign res_zero = (alu_res_i == '0);

  always_comb begin
    npc_o      = target_i;
    redirect_o = 1'b0;
    case (opcode_i)
      exu_pkg::OP_BRANCH: begin
        case (alu_op_i)
          // beq
          exu_pkg::ALU_SUB: redirect_o = res_zero;
          // bne, blt, bltu, bge, bgeu
          exu_pkg::ALU_XOR,
          exu_pkg::ALU_SLT,
          exu_pkg::ALU_SLTU,
          exu_pkg::ALU_SGE,
          exu_pkg::ALU_SGEU: redirect_o = !res_zero;
          default: redirect_o = 1'b0;
        endcase
      end
      exu_pkg::OP_JAL,
      exu_pkg::OP_JALR: begin
        redirect_o = 1'b1;
      end
      exu_pkg::OP_SYSTEM: begin
        if (sys_op_i == exu_pkg::SYS_ECALL) begin
          redirect_o = 1'b1;
          npc_o      = mtvec_i;
        end else if (sys_op_i == exu_pkg::SYS_MRET) begin
          redirect_o = 1'b1;
          npc_o      = mepc_i;
        end
      end
      default: begin
        redirect_o = 1'b0;
      end
    endcase
  end

endmodule

/* exu_csr.sv */
`timescale 1ns/1ps

module exu_csr (
  input  logic                clk,
  input  logic                rst,
  input  logic                commit_i,
  input  exu_pkg::sys_op_t    op_i,
  input  exu_pkg::csr_addr_t  addr_i,
  input  exu_pkg::word_t      src_i,
  input  exu_pkg::word_t      pc_i,
  output exu_pkg::word_t      rdata_o,
  output exu_pkg::word_t      mtvec_o,
  output exu_pkg::word_t      mepc_o
);

  exu_pkg::word_t mstatus_q, mtvec_q, mepc_q, mcause_q;
  exu_pkg::word_t wdata;

  always_comb begin
    case (addr_i)
      exu_pkg::CSR_MSTATUS: rdata_o = mstatus_q;
      exu_pkg::CSR_MTVEC:   rdata_o = mtvec_q;
      exu_pkg::CSR_MEPC:    rdata_o = mepc_q;
      exu_pkg::CSR_MCAUSE:  rdata_o = mcause_q;
      default:              rdata_o = '0;
    endcase
  end

  // new value for the addressed csr
  always_comb begin
    case (op_i)
      exu_pkg::SYS_CSRRS: wdata = rdata_o | src_i;
      exu_pkg::SYS_CSRRC: wdata = rdata_o & ~src_i;
      default:            wdata = src_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      case (op_i)
        exu_pkg::SYS_CSRRW,
        exu_pkg::SYS_CSRRS,
        exu_pkg::SYS_CSRRC: begin
          case (addr_i)
            exu_pkg::CSR_MSTATUS: mstatus_q <= wdata;
            exu_pkg::CSR_MTVEC:   mtvec_q   <= wdata;
            exu_pkg::CSR_MEPC:    mepc_q    <= wdata;
            exu_pkg::CSR_MCAUSE:  mcause_q  <= wdata;
            default: ;
          endcase
        end
        exu_pkg::SYS_ECALL: begin
          mepc_q   <= pc_i;
          mcause_q <= exu_pkg::CAUSE_ECALL_M;
        end
        exu_pkg::SYS_MRET: begin
          // mie from mpie and mpie set
          mstatus_q[3] <= mstatus_q[7];
          mstatus_q[7] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

/* exu_lsu_mem.sv */
`timescale 1ns/1ps

module exu_lsu_mem #(
  parameter int unsigned MEM_WORDS = 256,
  parameter int unsigned LSU_DELAY = 3
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           req_i,
  input  logic           we_i,
  input  exu_pkg::word_t addr_i,
  input  exu_pkg::word_t wdata_i,
  output logic           resp_o,
  output exu_pkg::word_t rdata_o
);

  localparam int CNT_W = (LSU_DELAY > 1) ? $clog2(LSU_DELAY) : 1;

  exu_pkg::lsu_state_e state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                resp_q;
  // request already served until it drops
  logic                done_q;
  logic                fire;
  exu_pkg::word_t      word_idx;
  exu_pkg::word_t      rdata_q;
  exu_pkg::word_t      mem_q [MEM_WORDS];

  assign word_idx = (addr_i >> 2) % MEM_WORDS;
  assign fire     = (state_q == exu_pkg::LSU_COUNT) && (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= exu_pkg::LSU_IDLE;
      cnt_q   <= '0;
      resp_q  <= 1'b0;
      done_q  <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      resp_q <= 1'b0;
      if (!req_i) begin
        done_q <= 1'b0;
      end
      case (state_q)
        exu_pkg::LSU_IDLE: begin
          if (req_i && !done_q) begin
            state_q <= exu_pkg::LSU_COUNT;
            cnt_q   <= CNT_W'(LSU_DELAY - 1);
          end
        end
        exu_pkg::LSU_COUNT: begin
          if (fire) begin
            state_q <= exu_pkg::LSU_IDLE;
            resp_q  <= 1'b1;
            done_q  <= 1'b1;
            if (we_i) begin
              mem_q[word_idx] <= wdata_i;
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= exu_pkg::LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire && !we_i) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign resp_o  = resp_q;
  assign rdata_o = rdata_q;

endmodule

/* exu_stage.sv */
`timescale 1ns/1ps

module exu_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  input  exu_pkg::exu_issue_t  issue_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output exu_pkg::exu_result_t result_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output exu_pkg::word_t       mem_addr_o,
  output exu_pkg::word_t       mem_wdata_o,
  input  logic                 mem_resp_i,
  input  exu_pkg::word_t       mem_rdata_i
);

  exu_pkg::exu_issue_t iss_q;
  exu_pkg::mem_state_e state_q;
  logic                out_valid_q;
  logic                mem_req_q;
  exu_pkg::word_t      load_q;

  logic               accept;
  logic               is_mem;
  logic               is_sys;
  exu_pkg::word_t     alu_b;
  exu_pkg::word_t     alu_res;
  exu_pkg::word_t     target;
  exu_pkg::word_t     mtvec, mepc;
  exu_pkg::word_t     csr_rdata;
  exu_pkg::sys_op_t   csr_op;
  exu_pkg::csr_addr_t csr_addr;
  exu_pkg::word_t     csr_src;
  logic               commit;
  logic               no_write;

  assign in_ready_o = (state_q == exu_pkg::MEM_IDLE) && (!out_valid_q || out_ready_i);
  assign accept     = in_valid_i && in_ready_o;
  assign is_mem     = (issue_i.opcode == exu_pkg::OP_LOAD) ||
                      (issue_i.opcode == exu_pkg::OP_STORE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= exu_pkg::MEM_IDLE;
      out_valid_q <= 1'b0;
      mem_req_q   <= 1'b0;
    end else begin
      if (out_valid_q && out_ready_i) begin
        out_valid_q <= 1'b0;
      end
      case (state_q)
        exu_pkg::MEM_IDLE: begin
          if (accept) begin
            if (is_mem) begin
              state_q   <= exu_pkg::MEM_WAIT;
              mem_req_q <= 1'b1;
            end else begin
              out_valid_q <= 1'b1;
            end
          end
        end
        exu_pkg::MEM_WAIT: begin
          if (mem_resp_i) begin
            state_q     <= exu_pkg::MEM_IDLE;
            mem_req_q   <= 1'b0;
            out_valid_q <= 1'b1;
          end
        end
        default: state_q <= exu_pkg::MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss_q <= issue_i;
    end
    if (state_q == exu_pkg::MEM_WAIT && mem_resp_i) begin
      load_q <= mem_rdata_i;
    end
  end

  assign mem_req_o   = mem_req_q;
  assign mem_we_o    = (iss_q.opcode == exu_pkg::OP_STORE);
  assign mem_addr_o  = iss_q.op1 + iss_q.imm;
  assign mem_wdata_o = iss_q.op2;

  // immediate forms take imm as second operand
  assign alu_b  = (iss_q.opcode == exu_pkg::OP_I) ? iss_q.imm : iss_q.op2;
  assign target = (iss_q.opcode == exu_pkg::OP_JALR) ? iss_q.op1 + iss_q.imm
                                                     : iss_q.pc + iss_q.imm;

  exu_alu u_alu (
    .a_i   (iss_q.op1),
    .b_i   (alu_b),
    .op_i  (iss_q.alu_op),
    .res_o (alu_res)
  );

  exu_branch u_branch (
    .opcode_i   (iss_q.opcode),
    .alu_op_i   (iss_q.alu_op),
    .sys_op_i   (iss_q.sys_op),
    .alu_res_i  (alu_res),
    .target_i   (target),
    .mtvec_i    (mtvec),
    .mepc_i     (mepc),
    .npc_o      (result_o.npc),
    .redirect_o (result_o.redirect)
  );

  // csr side effects only when the result leaves
  assign is_sys   = (iss_q.opcode == exu_pkg::OP_SYSTEM);
  assign csr_op   = is_sys ? iss_q.sys_op : exu_pkg::SYS_NONE;
  assign csr_addr = iss_q.csr;
  assign csr_src  = iss_q.op1;
  assign commit   = out_valid_q && out_ready_i && is_sys;

  exu_csr u_csr (
    .clk      (clk),
    .rst      (rst),
    .commit_i (commit),
    .op_i     (csr_op),
    .addr_i   (csr_addr),
    .src_i    (csr_src),
    .pc_i     (iss_q.pc),
    .rdata_o  (csr_rdata),
    .mtvec_o  (mtvec),
    .mepc_o   (mepc)
  );

  assign no_write = (iss_q.opcode == exu_pkg::OP_STORE) ||
                    (iss_q.opcode == exu_pkg::OP_BRANCH) ||
                    (is_sys && (iss_q.sys_op == exu_pkg::SYS_ECALL ||
                                iss_q.sys_op == exu_pkg::SYS_MRET ||
                                iss_q.sys_op == exu_pkg::SYS_EBREAK));

  always_comb begin
    case (iss_q.opcode)
      exu_pkg::OP_LOAD:   result_o.wdata = load_q;
      exu_pkg::OP_SYSTEM: result_o.wdata = csr_rdata;
      exu_pkg::OP_JAL,
      exu_pkg::OP_JALR:   result_o.wdata = iss_q.pc + 32'd4;
      default:            result_o.wdata = alu_res;
    endcase
  end

  assign result_o.rd     = iss_q.rd;
  assign result_o.rd_we  = !no_write;
  assign result_o.ebreak = is_sys && (iss_q.sys_op == exu_pkg::SYS_EBREAK);
  assign out_valid_o     = out_valid_q;

endmodule

/* exu_top.sv */
`timescale 1ns/1ps

module exu_top #(
  parameter int unsigned MEM_WORDS = 256,
  parameter int unsigned LSU_DELAY = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  input  exu_pkg::exu_issue_t  issue_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output exu_pkg::exu_result_t result_o
);

  logic           mem_req;
  logic           mem_we;
  exu_pkg::word_t mem_addr;
  exu_pkg::word_t mem_wdata;
  logic           mem_resp;
  exu_pkg::word_t mem_rdata;

  exu_stage u_stage (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .issue_i     (issue_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_resp_i  (mem_resp),
    .mem_rdata_i (mem_rdata)
  );

  exu_lsu_mem #(
    .MEM_WORDS (MEM_WORDS),
    .LSU_DELAY (LSU_DELAY)
  ) u_mem (
    .clk     (clk),
    .rst     (rst),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .resp_o  (mem_resp),
    .rdata_o (mem_rdata)
  );

endmodule

/* exu_props.sv */
`timescale 1ns/1ps

module exu_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 in_ready_i,
  input logic                 out_valid_i,
  input logic                 out_ready_i,
  input exu_pkg::exu_result_t result_i,
  input logic                 mem_req_i,
  input logic                 mem_resp_i
);

  int unsigned fail_count = 0;

  // nothing valid out of reset
  a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid_i)
    else begin
      fail_count++;
      $error("out_valid_o high after reset");
    end

  a_result_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i))
    else begin
      fail_count++;
      $error("result_o changed while out_ready_i was low");
    end

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_i && !mem_resp_i |=> mem_req_i)
    else begin
      fail_count++;
      $error("mem_req_o dropped before mem_resp_i");
    end

  // one instruction in flight
  a_busy_no_accept: assert property (@(posedge clk) disable iff (rst)
    mem_req_i |-> !in_ready_i)
    else begin
      fail_count++;
      $error("in_ready_o high with a memory access pending");
    end

endmodule

/* tb_exu_top.sv */
`timescale 1ns/1ps

module tb_exu_top;

  localparam int LSU_DELAY    = 3;
  localparam int MEM_WORDS    = 256;
  localparam int RESET_CYCLES = 16;
  localparam int STALL_CYCLES = 6;
  localparam int SEED         = 68;
  // about 100 instructions each bounded by a memory access plus a stall
  localparam int MAX_INSTR       = 100;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_INSTR * (LSU_DELAY + STALL_CYCLES + 10);

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  exu_pkg::exu_issue_t  issue;
  logic                 in_ready;
  logic                 out_valid;
  logic                 out_ready;
  exu_pkg::exu_result_t result;
  int                   errors = 0;
  int                   checks = 0;

  exu_top #(
    .MEM_WORDS (MEM_WORDS),
    .LSU_DELAY (LSU_DELAY)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .issue_i     (issue),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result)
  );

  bind exu_stage exu_props u_props (
    .clk         (clk),
    .rst         (rst),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_i    (result_o),
    .mem_req_i   (mem_req_o),
    .mem_resp_i  (mem_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  task automatic word_eq(input string name, input exu_pkg::word_t exp, input exu_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic idx_eq(input string name, input exu_pkg::reg_idx_t exp,
                        input exu_pkg::reg_idx_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic flag_eq(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic flags_eq(input string tag, input exu_pkg::exu_result_t res,
                          input exu_pkg::reg_idx_t rd, input logic we,
                          input logic redirect, input logic ebreak);
    idx_eq({tag, ".rd"}, rd, res.rd);
    flag_eq({tag, ".rd_we"}, we, res.rd_we);
    flag_eq({tag, ".redirect"}, redirect, res.redirect);
    flag_eq({tag, ".ebreak"}, ebreak, res.ebreak);
  endtask

  // reference ALU with signed compares by flipping the sign bit
  function automatic exu_pkg::word_t alu_model(input exu_pkg::alu_op_t op,
                                               input exu_pkg::word_t a, input exu_pkg::word_t b);
    exu_pkg::word_t fa;
    exu_pkg::word_t fb;
    logic [63:0]    ext;
    fa  = a ^ 32'h8000_0000;
    fb  = b ^ 32'h8000_0000;
    ext = {{32{a[31]}}, a};
    case (op)
      exu_pkg::ALU_ADD:  return a + b;
      exu_pkg::ALU_SUB:  return a + ~b + 32'd1;
      exu_pkg::ALU_AND:  return a & b;
      exu_pkg::ALU_OR:   return a | b;
      exu_pkg::ALU_XOR:  return a ^ b;
      exu_pkg::ALU_SLL:  return a << b[4:0];
      exu_pkg::ALU_SRL:  return a >> b[4:0];
      exu_pkg::ALU_SRA:  return 32'(ext >> b[4:0]);
      exu_pkg::ALU_SLT:  return (fa < fb) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SGE:  return (fa < fb) ? 32'd0 : 32'd1;
      exu_pkg::ALU_SGEU: return (a < b) ? 32'd0 : 32'd1;
      default:           return 32'd0;
    endcase
  endfunction

  // beq, bne, blt, bltu, bge, bgeu by compare op
  function automatic logic branch_taken(input exu_pkg::alu_op_t op,
                                        input exu_pkg::word_t a, input exu_pkg::word_t b);
    case (op)
      exu_pkg::ALU_SUB:  return a == b;
      exu_pkg::ALU_XOR:  return a != b;
      exu_pkg::ALU_SLT:  return $signed(a) < $signed(b);
      exu_pkg::ALU_SLTU: return a < b;
      exu_pkg::ALU_SGE:  return $signed(a) >= $signed(b);
      exu_pkg::ALU_SGEU: return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic exu_pkg::exu_issue_t build_issue(
    input exu_pkg::opcode_t  opcode,
    input exu_pkg::alu_op_t  alu_op,
    input exu_pkg::reg_idx_t rd,
    input exu_pkg::word_t    op1,
    input exu_pkg::word_t    op2,
    input exu_pkg::word_t    imm,
    input exu_pkg::word_t    pc
  );
    exu_pkg::exu_issue_t iss;
    iss        = '0;
    iss.opcode = opcode;
    iss.alu_op = alu_op;
    iss.sys_op = exu_pkg::SYS_NONE;
    iss.rd     = rd;
    iss.op1    = op1;
    iss.op2    = op2;
    iss.imm    = imm;
    iss.pc     = pc;
    return iss;
  endfunction

  function automatic exu_pkg::exu_issue_t sys_issue(
    input exu_pkg::sys_op_t   op,
    input exu_pkg::csr_addr_t csr,
    input exu_pkg::reg_idx_t  rd,
    input exu_pkg::word_t     src,
    input exu_pkg::word_t     pc
  );
    exu_pkg::exu_issue_t iss;
    iss        = build_issue(exu_pkg::OP_SYSTEM, exu_pkg::ALU_ADD, rd, src, 32'd0, 32'd0, pc);
    iss.sys_op = op;
    iss.csr    = csr;
    return iss;
  endfunction

  // issue one instruction, wait for its result and check the latency
  task automatic execute(input exu_pkg::exu_issue_t iss, output exu_pkg::exu_result_t res);
    int edges;
    int exp_edges;
    @(posedge clk);
    in_valid <= 1'b1;
    issue    <= iss;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    // handshake completes on this edge
    @(posedge clk);
    in_valid <= 1'b0;
    edges = 0;
    @(negedge clk);
    while (!out_valid) begin
      edges++;
      @(negedge clk);
    end
    res = result;
    if (iss.opcode == exu_pkg::OP_LOAD || iss.opcode == exu_pkg::OP_STORE) begin
      exp_edges = LSU_DELAY + 2;
    end else begin
      exp_edges = 0;
    end
    word_eq("latency", 32'(exp_edges), 32'(edges));
  endtask

  task automatic alu_ops();
    exu_pkg::exu_result_t res;
    exu_pkg::alu_op_t     code;
    exu_pkg::word_t       a;
    exu_pkg::word_t       b;
    exu_pkg::reg_idx_t    rd;
    for (int op = 0; op < 12; op++) begin
      code = 4'(op);
      for (int n = 0; n < 3; n++) begin
        a  = $urandom();
        b  = $urandom();
        rd = 4'(op + n + 1);
        execute(build_issue(exu_pkg::OP_R, code, rd, a, b, 32'd0, 32'd0), res);
        flags_eq("alu_r", res, rd, 1'b1, 1'b0, 1'b0);
        word_eq("alu_r.wdata", alu_model(code, a, b), res.wdata);
      end
      // immediate form with the second operand from imm
      execute(build_issue(exu_pkg::OP_I, code, 4'd9, a, 32'd0, b, 32'd0), res);
      flags_eq("alu_i", res, 4'd9, 1'b1, 1'b0, 1'b0);
      word_eq("alu_i.wdata", alu_model(code, a, b), res.wdata);
    end
  endtask

  task automatic branch_jumps();
    exu_pkg::exu_result_t res;
    exu_pkg::alu_op_t     ops [6];
    exu_pkg::word_t       lhs [4];
    exu_pkg::word_t       rhs [4];
    exu_pkg::word_t       pc;
    exu_pkg::word_t       imm;
    logic                 taken;
    ops = '{exu_pkg::ALU_SUB, exu_pkg::ALU_XOR, exu_pkg::ALU_SLT,
            exu_pkg::ALU_SLTU, exu_pkg::ALU_SGE, exu_pkg::ALU_SGEU};
    // equal, less, greater, then signed less but unsigned greater
    lhs = '{32'd77, 32'd5, 32'd900, 32'hffff_fff0};
    rhs = '{32'd77, 32'd9, 32'd12, 32'h0000_0010};
    pc  = 32'h0000_1000;
    foreach (ops[i]) begin
      foreach (lhs[j]) begin
        imm   = 32'((j + 1) * 16);
        taken = branch_taken(ops[i], lhs[j], rhs[j]);
        execute(build_issue(exu_pkg::OP_BRANCH, ops[i], 4'd0, lhs[j], rhs[j], imm, pc), res);
        flags_eq("branch", res, 4'd0, 1'b0, taken, 1'b0);
        if (taken) begin
          word_eq("branch.npc", pc + imm, res.npc);
        end
        pc = pc + 32'd4;
      end
    end
    execute(build_issue(exu_pkg::OP_JAL, exu_pkg::ALU_ADD, 4'd1, 32'd0, 32'd0,
                        32'h0000_0100, 32'h0000_2000), res);
    flags_eq("jal", res, 4'd1, 1'b1, 1'b1, 1'b0);
    word_eq("jal.npc", 32'h0000_2100, res.npc);
    word_eq("jal.wdata", 32'h0000_2004, res.wdata);
    execute(build_issue(exu_pkg::OP_JALR, exu_pkg::ALU_ADD, 4'd2, 32'h0000_3000, 32'd0,
                        32'h0000_0024, 32'h0000_2100), res);
    flags_eq("jalr", res, 4'd2, 1'b1, 1'b1, 1'b0);
    word_eq("jalr.npc", 32'h0000_3024, res.npc);
    word_eq("jalr.wdata", 32'h0000_2104, res.wdata);
  endtask

  task automatic load_store();
    exu_pkg::exu_result_t res;
    exu_pkg::word_t       addrs [4];
    exu_pkg::word_t       data [4];
    addrs = '{32'h0000_0040, 32'h0000_0044, 32'h0000_01f0, 32'h0000_03fc};
    foreach (addrs[i]) begin
      data[i] = $urandom();
      execute(build_issue(exu_pkg::OP_STORE, exu_pkg::ALU_ADD, 4'd0, addrs[i] - 32'h10,
                          data[i], 32'h10, 32'd0), res);
      flags_eq("store", res, 4'd0, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 3; i >= 0; i--) begin
      execute(build_issue(exu_pkg::OP_LOAD, exu_pkg::ALU_ADD, 4'd5, addrs[i], 32'd0,
                          32'd0, 32'd0), res);
      flags_eq("load", res, 4'd5, 1'b1, 1'b0, 1'b0);
      word_eq("load.wdata", data[i], res.wdata);
    end
    // untouched word still zero
    execute(build_issue(exu_pkg::OP_LOAD, exu_pkg::ALU_ADD, 4'd6, 32'h0000_0200, 32'd0,
                        32'd0, 32'd0), res);
    word_eq("load_empty.wdata", 32'd0, res.wdata);
  endtask

  task automatic csr_access();
    exu_pkg::exu_result_t res;
    exu_pkg::word_t       w;
    exu_pkg::word_t       s;
    exu_pkg::word_t       c;
    w = $urandom();
    s = $urandom();
    c = $urandom();
    execute(sys_issue(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MTVEC, 4'd3, w, 32'd0), res);
    flags_eq("csrrw", res, 4'd3, 1'b1, 1'b0, 1'b0);
    word_eq("csrrw.wdata", 32'd0, res.wdata);
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MTVEC, 4'd3, s, 32'd0), res);
    word_eq("csrrs.wdata", w, res.wdata);
    execute(sys_issue(exu_pkg::SYS_CSRRC, exu_pkg::CSR_MTVEC, 4'd3, c, 32'd0), res);
    word_eq("csrrc.wdata", w | s, res.wdata);
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MTVEC, 4'd3, 32'd0, 32'd0), res);
    word_eq("mtvec.final", (w | s) & ~c, res.wdata);
  endtask

  task automatic trap_entry_exit();
    exu_pkg::exu_result_t res;
    exu_pkg::word_t       vec;
    exu_pkg::word_t       epc;
    vec = 32'h0000_0100;
    epc = 32'h0000_0a40;
    execute(sys_issue(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MTVEC, 4'd1, vec, 32'd0), res);
    execute(sys_issue(exu_pkg::SYS_ECALL, '0, 4'd0, 32'd0, epc), res);
    flags_eq("ecall", res, 4'd0, 1'b0, 1'b1, 1'b0);
    word_eq("ecall.npc", vec, res.npc);
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MEPC, 4'd4, 32'd0, 32'd0), res);
    word_eq("mepc", epc, res.wdata);
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MCAUSE, 4'd4, 32'd0, 32'd0), res);
    word_eq("mcause", 32'd11, res.wdata);
    execute(sys_issue(exu_pkg::SYS_MRET, '0, 4'd0, 32'd0, 32'h0000_0104), res);
    flags_eq("mret", res, 4'd0, 1'b0, 1'b1, 1'b0);
    word_eq("mret.npc", epc, res.npc);
    // mpie set and mie copied from the old mpie
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MSTATUS, 4'd4, 32'd0, 32'd0), res);
    word_eq("mstatus", 32'h0000_0080, res.wdata);
    execute(sys_issue(exu_pkg::SYS_EBREAK, '0, 4'd0, 32'd0, 32'h0000_0200), res);
    flags_eq("ebreak", res, 4'd0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic back_pressure();
    exu_pkg::exu_result_t held;
    exu_pkg::exu_result_t res;
    @(posedge clk);
    out_ready <= 1'b0;
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MSTATUS, 4'd6, 32'h8, 32'd0), held);
    flags_eq("stall", held, 4'd6, 1'b1, 1'b0, 1'b0);
    word_eq("stall.wdata", 32'h0000_0080, held.wdata);
    repeat (STALL_CYCLES) begin
      @(negedge clk);
      flag_eq("stall.out_valid", 1'b1, out_valid);
      flag_eq("stall.in_ready", 1'b0, in_ready);
      word_eq("stall.result.wdata", 32'h0000_0080, result.wdata);
      idx_eq("stall.result.rd", 4'd6, result.rd);
      flag_eq("stall.result.rd_we", 1'b1, result.rd_we);
      flag_eq("stall.result.redirect", 1'b0, result.redirect);
    end
    @(posedge clk);
    out_ready <= 1'b1;
    execute(sys_issue(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MSTATUS, 4'd6, 32'd0, 32'd0), res);
    word_eq("stall.mstatus", 32'h0000_0088, res.wdata);
  endtask

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    in_valid  = 1'b0;
    issue     = '0;
    out_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    flag_eq("reset.out_valid", 1'b0, out_valid);
    flag_eq("reset.in_ready", 1'b1, in_ready);
    alu_ops();
    branch_jumps();
    load_store();
    csr_access();
    trap_entry_exit();
    back_pressure();
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             UUT.u_stage.u_props.fail_count);
    if (errors == 0 && UUT.u_stage.u_props.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* flist.f */
exu_pkg.sv
exu_alu.sv
exu_branch.sv
exu_csr.sv
exu_lsu_mem.sv
exu_stage.sv
exu_top.sv
exu_props.sv
tb_exu_top.sv

/* Bender.yml */
package:
  name: exu

sources:
  - files:
      - exu_pkg.sv
      - exu_alu.sv
      - exu_branch.sv
      - exu_csr.sv
      - exu_lsu_mem.sv
      - exu_stage.sv
      - exu_top.sv
  - target: test
    files:
      - exu_props.sv
      - tb_exu_top.sv
